/* cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_SIZE = 16;
	localparam int NUM_REGS  = 4;

	// Instruction field positions
	localparam int OPCODE_MSB = 15;
	localparam int OPCODE_LSB = 12;
	localparam int RS_MSB     = 11;
	localparam int RS_LSB     = 10;
	localparam int RT_MSB     = 9;
	localparam int RT_LSB     = 8;
	localparam int RD_MSB     = 7;
	localparam int RD_LSB     = 6;
	localparam int FUNC_MSB   = 5;
	localparam int FUNC_LSB   = 0;
	localparam int IMM_MSB    = 7;
	localparam int IMM_LSB    = 0;
	localparam int TARGET_MSB = 11;
	localparam int TARGET_LSB = 0;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_LHI,
		ALU_PASS_B,
		ALU_EQ,
		ALU_NE
	} alu_op_e;

	typedef enum logic {WB_ALU, WB_MEM} wb_src_e;
	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_src_e;

endpackage

/* control_unit.sv */
module control_unit import cpu_pkg::*; (
	input  logic [WORD_SIZE-1:0] instr,
	output alu_op_e              alu_op,
	output logic                 alu_src_imm,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 reg_write,
	output wb_src_e              wb_src,
	output pc_src_e              pc_src,
	output logic                 wwd,
	output logic                 halt,
	output logic                 use_rs,
	output logic                 use_rt,
	output logic                 rd_sel,
	output logic [WORD_SIZE-1:0] immediate
);

	opcode_e                  opcode;
	func_e                    func;
	logic [IMM_MSB:IMM_LSB]   imm;

	assign opcode = opcode_e'(instr[OPCODE_MSB:OPCODE_LSB]);
	assign func   = func_e'(instr[FUNC_MSB:FUNC_LSB]);
	assign imm    = instr[IMM_MSB:IMM_LSB];

	// ORI takes its immediate unsigned
	assign immediate = (opcode == OP_ORI) ? {{(WORD_SIZE-8){1'b0}}, imm}
		: {{(WORD_SIZE-8){imm[IMM_MSB]}}, imm};

	always_comb begin
		alu_op      = ALU_PASS_B;
		alu_src_imm = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		reg_write   = 1'b0;
		wb_src      = WB_ALU;
		pc_src      = PC_SEQ;
		wwd         = 1'b0;
		halt        = 1'b0;
		use_rs      = 1'b0;
		use_rt      = 1'b0;
		rd_sel      = 1'b0;
		case (opcode)
			OP_ADI, OP_ORI: begin
				alu_op      = (opcode == OP_ADI) ? ALU_ADD : ALU_ORR;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				use_rs      = 1'b1;
			end
			OP_LHI: begin
				alu_op      = ALU_LHI;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			OP_LWD, OP_SWD: begin
				// Address is rs plus offset
				alu_op      = ALU_ADD;
				alu_src_imm = 1'b1;
				use_rs      = 1'b1;
				mem_read    = (opcode == OP_LWD);
				reg_write   = (opcode == OP_LWD);
				mem_write   = (opcode == OP_SWD);
				use_rt      = (opcode == OP_SWD);
				wb_src      = (opcode == OP_LWD) ? WB_MEM : WB_ALU;
			end
			OP_BNE, OP_BEQ: begin
				alu_op = (opcode == OP_BNE) ? ALU_NE : ALU_EQ;
				pc_src = PC_BRANCH;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			OP_JMP: begin
				pc_src = PC_JUMP;
			end
			OP_RTYPE: begin
				use_rs = 1'b1;
				rd_sel = 1'b1;
				wwd    = (func == FN_WWD);
				halt   = (func == FN_HLT);
				case (func)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_ORR: alu_op = ALU_ORR;
					FN_NOT: alu_op = ALU_NOT;
					FN_TCP: alu_op = ALU_TCP;
					FN_SHL: alu_op = ALU_SHL;
					FN_SHR: alu_op = ALU_SHR;
					default: alu_op = ALU_PASS_B;
				endcase
				// WWD, HLT and unknown functions write nothing
				reg_write = (alu_op != ALU_PASS_B);
				use_rt    = (func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});
			end
			default: begin
			end
		endcase
	end

endmodule

/* register_file.sv */
module register_file import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [1:0]           read1,
	input  logic [1:0]           read2,
	input  logic [1:0]           dest,
	input  logic                 reg_write,
	input  logic [WORD_SIZE-1:0] write_data,
	output logic [WORD_SIZE-1:0] read_out1,
	output logic [WORD_SIZE-1:0] read_out2
);

	logic [WORD_SIZE-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[dest] <= write_data;
		end
	end

	// Value written by WB this cycle goes straight to ID
	assign read_out1 = (reg_write && dest == read1) ? write_data : regs[read1];
	assign read_out2 = (reg_write && dest == read2) ? write_data : regs[read2];

endmodule

/* alu.sv */
module alu import cpu_pkg::*; (
	input  logic [WORD_SIZE-1:0] a,
	input  logic [WORD_SIZE-1:0] b,
	input  alu_op_e              op,
	output logic [WORD_SIZE-1:0] result,
	output logic                 bcond
);

	localparam int HALF = WORD_SIZE / 2;

	always_comb begin
		bcond = 1'b0;
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 1'b1;
			ALU_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
			// Sign bit is kept on a right shift
			ALU_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
			// Low byte of the immediate moves to the top
			ALU_LHI: result = {b[HALF-1:0], {HALF{1'b0}}};
			ALU_PASS_B: result = b;
			ALU_EQ: begin
				bcond  = (a == b);
				result = a - b;
			end
			ALU_NE: begin
				bcond  = (a != b);
				result = a - b;
			end
			default: result = '0;
		endcase
	end

endmodule

/* hazard_unit.sv */
module hazard_unit import cpu_pkg::*; (
	input  logic [1:0] rs_id,
	input  logic [1:0] rt_id,
	input  logic       use_rs,
	input  logic       use_rt,
	input  logic [1:0] rd_ex,
	input  logic       mem_read_ex,
	input  logic [1:0] rs_ex,
	input  logic [1:0] rt_ex,
	input  logic [1:0] rd_mem,
	input  logic       reg_write_mem,
	input  logic [1:0] rd_wb,
	input  logic       reg_write_wb,
	output logic       stall,
	output fwd_sel_e   fwd_a,
	output fwd_sel_e   fwd_b
);

	// Load data only exists from WB on, so its consumer waits a cycle
	assign stall = mem_read_ex
		&& ((use_rs && rs_id == rd_ex) || (use_rt && rt_id == rd_ex));

	// Youngest producer wins, hence MEM before WB
	always_comb begin
		fwd_a = FWD_NONE;
		if (reg_write_mem && rd_mem == rs_ex) begin
			fwd_a = FWD_MEM;
		end else if (reg_write_wb && rd_wb == rs_ex) begin
			fwd_a = FWD_WB;
		end
	end

	always_comb begin
		fwd_b = FWD_NONE;
		if (reg_write_mem && rd_mem == rt_ex) begin
			fwd_b = FWD_MEM;
		end else if (reg_write_wb && rd_wb == rt_ex) begin
			fwd_b = FWD_WB;
		end
	end

endmodule

/* datapath.sv */
module datapath import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_n,
	output logic                 read_m1,
	output logic [WORD_SIZE-1:0] address1,
	input  logic [WORD_SIZE-1:0] data1,
	output logic                 read_m2,
	output logic                 write_m2,
	output logic [WORD_SIZE-1:0] address2,
	inout  wire  [WORD_SIZE-1:0] data2,
	output logic [WORD_SIZE-1:0] num_inst,
	output logic [WORD_SIZE-1:0] output_port,
	output logic                 is_halted
);

	// IF and IF/ID
	logic [WORD_SIZE-1:0] pc, pc_id, instr_id;
	logic                 valid_id, halt_pending, frozen;

	// ID decode
	alu_op_e              alu_op_id;
	wb_src_e              wb_src_id;
	pc_src_e              pc_src_id;
	logic                 alu_src_imm_id, mem_read_id, mem_write_id, reg_write_id;
	logic                 wwd_id, halt_id, use_rs, use_rt, rd_sel;
	logic [WORD_SIZE-1:0] imm_id, rs_val_id, rt_val_id;
	logic [1:0]           rs_id, rt_id, rd_id;
	logic                 stall, issue;

	// ID/EX
	logic [WORD_SIZE-1:0]       pc_ex, rs_val_ex, rt_val_ex, imm_ex;
	logic [TARGET_MSB:TARGET_LSB] target_ex;
	logic [1:0]                 rs_ex, rt_ex, rd_ex;
	alu_op_e                    alu_op_ex;
	wb_src_e                    wb_src_ex;
	pc_src_e                    pc_src_ex;
	logic                       valid_ex, alu_src_imm_ex, mem_read_ex, mem_write_ex;
	logic                       reg_write_ex, wwd_ex, halt_ex;

	// EX
	fwd_sel_e             fwd_a, fwd_b;
	logic [WORD_SIZE-1:0] a_val, b_fwd, alu_result, target_pc;
	logic                 bcond, taken;

	// EX/MEM and MEM/WB
	logic [WORD_SIZE-1:0] alu_result_mem, wdata_mem;
	logic [WORD_SIZE-1:0] alu_result_wb, mem_data_wb, wdata_wb, wb_data;
	logic [1:0]           rd_mem, rd_wb;
	wb_src_e              wb_src_mem, wb_src_wb;
	logic                 valid_mem, mem_read_mem, mem_write_mem, reg_write_mem, wwd_mem;
	logic                 halt_mem, valid_wb, reg_write_wb, wwd_wb, halt_wb;

	assign rs_id  = instr_id[RS_MSB:RS_LSB];
	assign rt_id  = instr_id[RT_MSB:RT_LSB];
	assign rd_id  = rd_sel ? instr_id[RD_MSB:RD_LSB] : instr_id[RT_MSB:RT_LSB];
	assign frozen = (valid_id && halt_id) || halt_pending;
	assign issue  = valid_id && !stall && !taken;

	// Taken branch beats a stall, which beats a halt freeze
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc           <= '0;
			valid_id     <= 1'b0;
			halt_pending <= 1'b0;
		end else begin
			if (taken) begin
				pc       <= target_pc;
				valid_id <= 1'b0;
			end else if (!stall) begin
				if (frozen) begin
					valid_id <= 1'b0;
				end else begin
					pc       <= pc + 1'b1;
					valid_id <= 1'b1;
				end
			end
			if (issue && halt_id) begin
				halt_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!taken && !stall && !frozen) begin
			instr_id <= data1;
			pc_id    <= pc;
		end
	end

	// ID/EX control, cleared for bubbles and flushed slots
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_ex     <= 1'b0;
			mem_read_ex  <= 1'b0;
			mem_write_ex <= 1'b0;
			reg_write_ex <= 1'b0;
			wwd_ex       <= 1'b0;
			halt_ex      <= 1'b0;
			pc_src_ex    <= PC_SEQ;
		end else begin
			valid_ex     <= issue;
			mem_read_ex  <= issue && mem_read_id;
			mem_write_ex <= issue && mem_write_id;
			reg_write_ex <= issue && reg_write_id;
			wwd_ex       <= issue && wwd_id;
			halt_ex      <= issue && halt_id;
			pc_src_ex    <= issue ? pc_src_id : PC_SEQ;
		end
	end

	always_ff @(posedge clk) begin
		pc_ex          <= pc_id;
		rs_val_ex      <= rs_val_id;
		rt_val_ex      <= rt_val_id;
		imm_ex         <= imm_id;
		target_ex      <= instr_id[TARGET_MSB:TARGET_LSB];
		rs_ex          <= rs_id;
		rt_ex          <= rt_id;
		rd_ex          <= rd_id;
		alu_op_ex      <= alu_op_id;
		alu_src_imm_ex <= alu_src_imm_id;
		wb_src_ex      <= wb_src_id;
	end

	// Forwarding muxes in EX
	always_comb begin
		case (fwd_a)
			FWD_MEM: a_val = alu_result_mem;
			FWD_WB:  a_val = wb_data;
			default: a_val = rs_val_ex;
		endcase
		case (fwd_b)
			FWD_MEM: b_fwd = alu_result_mem;
			FWD_WB:  b_fwd = wb_data;
			default: b_fwd = rt_val_ex;
		endcase
	end

	assign taken = (pc_src_ex == PC_JUMP) || (pc_src_ex == PC_BRANCH && bcond);
	assign target_pc = (pc_src_ex == PC_JUMP) ? {pc_ex[WORD_SIZE-1:TARGET_MSB+1], target_ex}
		: pc_ex + 1'b1 + imm_ex;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_mem     <= 1'b0;
			mem_read_mem  <= 1'b0;
			mem_write_mem <= 1'b0;
			reg_write_mem <= 1'b0;
			wwd_mem       <= 1'b0;
			halt_mem      <= 1'b0;
			valid_wb      <= 1'b0;
			reg_write_wb  <= 1'b0;
			wwd_wb        <= 1'b0;
			halt_wb       <= 1'b0;
		end else begin
			valid_mem     <= valid_ex;
			mem_read_mem  <= mem_read_ex;
			mem_write_mem <= mem_write_ex;
			reg_write_mem <= reg_write_ex;
			wwd_mem       <= wwd_ex;
			halt_mem      <= halt_ex;
			valid_wb      <= valid_mem;
			reg_write_wb  <= reg_write_mem;
			wwd_wb        <= wwd_mem;
			halt_wb       <= halt_mem;
		end
	end

	// WWD sends rs down the store-data slot
	always_ff @(posedge clk) begin
		alu_result_mem <= alu_result;
		wdata_mem      <= wwd_ex ? a_val : b_fwd;
		rd_mem         <= rd_ex;
		wb_src_mem     <= wb_src_ex;
		alu_result_wb  <= alu_result_mem;
		mem_data_wb    <= data2;
		wdata_wb       <= wdata_mem;
		rd_wb          <= rd_mem;
		wb_src_wb      <= wb_src_mem;
	end

	assign wb_data = (wb_src_wb == WB_MEM) ? mem_data_wb : alu_result_wb;

	// Retire
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst    <= '0;
			output_port <= '0;
			is_halted   <= 1'b0;
		end else begin
			if (valid_wb) begin
				num_inst <= num_inst + 1'b1;
			end
			if (wwd_wb) begin
				output_port <= wdata_wb;
			end
			if (halt_wb) begin
				is_halted <= 1'b1;
			end
		end
	end

	assign read_m1  = !is_halted;
	assign address1 = pc;
	assign read_m2  = mem_read_mem;
	assign write_m2 = mem_write_mem;
	assign address2 = alu_result_mem;
	assign data2    = write_m2 ? wdata_mem : 'z;

	control_unit u_control (
		.instr      (instr_id),
		.alu_op     (alu_op_id),
		.alu_src_imm(alu_src_imm_id),
		.mem_read   (mem_read_id),
		.mem_write  (mem_write_id),
		.reg_write  (reg_write_id),
		.wb_src     (wb_src_id),
		.pc_src     (pc_src_id),
		.wwd        (wwd_id),
		.halt       (halt_id),
		.use_rs     (use_rs),
		.use_rt     (use_rt),
		.rd_sel     (rd_sel),
		.immediate  (imm_id)
	);

	register_file u_regs (
		.clk       (clk),
		.reset_n   (reset_n),
		.read1     (rs_id),
		.read2     (rt_id),
		.dest      (rd_wb),
		.reg_write (reg_write_wb),
		.write_data(wb_data),
		.read_out1 (rs_val_id),
		.read_out2 (rt_val_id)
	);

	alu u_alu (
		.a     (a_val),
		.b     (alu_src_imm_ex ? imm_ex : b_fwd),
		.op    (alu_op_ex),
		.result(alu_result),
		.bcond (bcond)
	);

	hazard_unit u_hazard (
		.rs_id        (rs_id),
		.rt_id        (rt_id),
		.use_rs       (use_rs && valid_id),
		.use_rt       (use_rt && valid_id),
		.rd_ex        (rd_ex),
		.mem_read_ex  (mem_read_ex),
		.rs_ex        (rs_ex),
		.rt_ex        (rt_ex),
		.rd_mem       (rd_mem),
		.reg_write_mem(reg_write_mem),
		.rd_wb        (rd_wb),
		.reg_write_wb (reg_write_wb),
		.stall        (stall),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

endmodule

/* tb_cpu_props.sv */
module tb_cpu_props import cpu_pkg::*; (
	input logic                 clk,
	input logic                 reset_n,
	input logic                 read_m2,
	input logic                 write_m2,
	input logic                 is_halted,
	input logic [WORD_SIZE-1:0] num_inst
);

	timeunit 1ns;
	timeprecision 1ps;

	// Shared data bus carries one direction at a time
	one_direction: assert property (@(posedge clk) disable iff (!reset_n)
		!(read_m2 && write_m2))
		else $error("read_m2 and write_m2 are high together");

	quiet_after_reset: assert property (@(posedge clk) !reset_n |=> (!read_m2 && !write_m2))
		else $error("memory strobes not low in the cycle after reset");

	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> (is_halted && $stable(num_inst)))
		else $error("is_halted dropped or num_inst moved while halted");

	no_store_halted: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |-> !write_m2)
		else $error("write_m2 asserted while halted");

endmodule

bind datapath tb_cpu_props i_props (
	.clk      (clk),
	.reset_n  (reset_n),
	.read_m2  (read_m2),
	.write_m2 (write_m2),
	.is_halted(is_halted),
	.num_inst (num_inst)
);

/* tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD      = 4;
	localparam int          RESET_CYCLES    = 10;
	localparam int          NUM_PROGS       = 20;
	localparam int          PROG_LEN        = 40;
	localparam int          MEM_WORDS       = 64;
	localparam int          CYCLES_PER_PROG = 200;
	localparam int          HOLD_CYCLES     = 20;
	localparam logic [31:0] SEED            = 32'h631d;
	localparam func_e       ALU_FNS [8]     = '{FN_ADD, FN_SUB, FN_AND, FN_ORR,
		FN_NOT, FN_TCP, FN_SHL, FN_SHR};

	logic                 clk = 1'b0;
	logic                 reset_n;
	logic                 read_m1, read_m2, write_m2, is_halted;
	logic [WORD_SIZE-1:0] address1, address2, data1, num_inst, output_port;
	wire  [WORD_SIZE-1:0] data2;

	logic [WORD_SIZE-1:0] imem [MEM_WORDS];
	logic [WORD_SIZE-1:0] dmem [MEM_WORDS];
	logic [WORD_SIZE-1:0] prog [MEM_WORDS];
	logic [WORD_SIZE-1:0] init_mem [MEM_WORDS];
	logic [WORD_SIZE-1:0] ref_mem [MEM_WORDS];
	logic [WORD_SIZE-1:0] wwd_q [$];
	logic [WORD_SIZE-1:0] last_out, hold_inst, hold_out, hold_pc, hold_addr;
	int                   exp_count;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Upper address bits alias onto the 64-word memories
	assign data1 = imem[address1[5:0]];
	assign data2 = read_m2 ? dmem[address2[5:0]] : 'z;

	always @(posedge clk) begin
		if (write_m2) begin
			dmem[address2[5:0]] <= data2;
		end
	end

	datapath i_dut (
		.clk        (clk),
		.reset_n    (reset_n),
		.read_m1    (read_m1),
		.address1   (address1),
		.data1      (data1),
		.read_m2    (read_m2),
		.write_m2   (write_m2),
		.address2   (address2),
		.data2      (data2),
		.num_inst   (num_inst),
		.output_port(output_port),
		.is_halted  (is_halted)
	);

	task automatic expect_equal(input string name, input logic [WORD_SIZE-1:0] got,
			input logic [WORD_SIZE-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic [WORD_SIZE-1:0] random_instr(input int idx);
		logic [1:0] rs, rt, rd;
		logic [7:0] imm;
		int         room;
		rs   = 2'($urandom);
		rt   = 2'($urandom);
		rd   = 2'($urandom);
		imm  = 8'($urandom);
		// Forward distance that still lands on or before the HLT
		room = PROG_LEN - 1 - idx;
		case ($urandom % 13)
			0: return {OP_ADI, rs, rt, imm};
			1: return {OP_ORI, rs, rt, imm};
			2: return {OP_LHI, rs, rt, imm};
			3: return {OP_LWD, rs, rt, imm};
			4: return {OP_SWD, rs, rt, imm};
			5: return {OP_BNE, rs, rt, 8'($urandom % (room + 1))};
			6: return {OP_BEQ, rs, rt, 8'($urandom % (room + 1))};
			7: return {OP_JMP, 12'(idx + 1 + int'($urandom % (room + 1)))};
			8: return {OP_RTYPE, rs, rt, rd, FN_WWD};
			default: return {OP_RTYPE, rs, rt, rd, ALU_FNS[$urandom % 8]};
		endcase
	endfunction

	task automatic build_program();
		for (int i = 0; i < MEM_WORDS; i++) begin
			prog[i]     = {OP_RTYPE, 6'b0, FN_HLT};
			init_mem[i] = 16'($urandom);
		end
		// LHI then ORI gives every register a known base
		for (int i = 0; i < PROG_LEN; i++) begin
			if (i < NUM_REGS) begin
				prog[i] = {OP_LHI, 2'b00, 2'(i), 8'($urandom)};
			end else if (i < 2 * NUM_REGS) begin
				prog[i] = {OP_ORI, 2'(i), 2'(i), 8'($urandom)};
			end else begin
				prog[i] = random_instr(i);
			end
		end
	endtask

	// ISA model stepping one instruction at a time
	task automatic run_model();
		logic [WORD_SIZE-1:0] regs [NUM_REGS];
		logic [WORD_SIZE-1:0] pc, next_pc, ins, a, b, simm, addr, last;
		logic [1:0]           rt, rd;
		logic                 done;
		regs      = '{default: '0};
		pc        = '0;
		last      = '0;
		done      = 1'b0;
		exp_count = 0;
		wwd_q.delete();
		ref_mem = init_mem;
		while (!done && exp_count < MEM_WORDS) begin
			ins     = prog[pc[5:0]];
			a       = regs[ins[RS_MSB:RS_LSB]];
			b       = regs[ins[RT_MSB:RT_LSB]];
			rt      = ins[RT_MSB:RT_LSB];
			rd      = ins[RD_MSB:RD_LSB];
			simm    = {{8{ins[IMM_MSB]}}, ins[IMM_MSB:IMM_LSB]};
			addr    = a + simm;
			next_pc = pc + 16'd1;
			exp_count++;
			case (opcode_e'(ins[OPCODE_MSB:OPCODE_LSB]))
				OP_ADI: regs[rt] = a + simm;
				OP_ORI: regs[rt] = a | {8'h00, ins[IMM_MSB:IMM_LSB]};
				OP_LHI: regs[rt] = {ins[IMM_MSB:IMM_LSB], 8'h00};
				OP_LWD: regs[rt] = ref_mem[addr[5:0]];
				OP_SWD: ref_mem[addr[5:0]] = b;
				OP_BNE: if (a != b) next_pc = pc + 16'd1 + simm;
				OP_BEQ: if (a == b) next_pc = pc + 16'd1 + simm;
				OP_JMP: next_pc = {pc[15:12], ins[TARGET_MSB:TARGET_LSB]};
				OP_RTYPE: begin
					case (func_e'(ins[FUNC_MSB:FUNC_LSB]))
						FN_ADD: regs[rd] = a + b;
						FN_SUB: regs[rd] = a - b;
						FN_AND: regs[rd] = a & b;
						FN_ORR: regs[rd] = a | b;
						FN_NOT: regs[rd] = ~a;
						FN_TCP: regs[rd] = -a;
						FN_SHL: regs[rd] = a << 1;
						FN_SHR: regs[rd] = {a[15], a[15:1]};
						FN_WWD: begin
							// The port only shows a change, so equal repeats merge
							if (a != last) begin
								wwd_q.push_back(a);
								last = a;
							end
						end
						FN_HLT: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = next_pc;
		end
	endtask

	task automatic watch_output();
		if (output_port !== last_out) begin
			if (wwd_q.size() == 0) begin
				$display("output_port changed to %h with no WWD value left in the model",
					output_port);
				$display("TEST RESULT: FAIL");
				$fatal(1, "unexpected output_port change");
			end else begin
				expect_equal("output_port", output_port, wwd_q.pop_front());
				last_out = output_port;
			end
		end
	endtask

	initial begin
		#(NUM_PROGS * CYCLES_PER_PROG * CLK_PERIOD);
		$display("Watchdog expired before all programs halted");
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		reset_n = 1'b0;
		void'($urandom(SEED));
		for (int p = 0; p < NUM_PROGS; p++) begin
			build_program();
			run_model();
			@(posedge clk);
			reset_n <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				imem[i] <= prog[i];
				dmem[i] <= init_mem[i];
			end
			repeat (RESET_CYCLES) @(posedge clk);
			reset_n <= 1'b1;
			@(negedge clk);
			last_out = '0;
			expect_equal("num_inst", num_inst, '0);
			expect_equal("output_port", output_port, '0);
			expect_equal("is_halted", 16'(is_halted), 16'd0);
			while (is_halted !== 1'b1) begin
				expect_equal("read_m1", 16'(read_m1), 16'd1);
				watch_output();
				@(negedge clk);
			end
			watch_output();
			expect_equal("num_inst", num_inst, 16'(exp_count));
			for (int i = 0; i < MEM_WORDS; i++) begin
				expect_equal($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i]);
			end
			// Halted core must stay frozen
			hold_inst = num_inst;
			hold_out  = output_port;
			hold_pc   = address1;
			hold_addr = address2;
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				watch_output();
				expect_equal("is_halted", 16'(is_halted), 16'd1);
				expect_equal("write_m2", 16'(write_m2), 16'd0);
				expect_equal("read_m2", 16'(read_m2), 16'd0);
				expect_equal("read_m1", 16'(read_m1), 16'd0);
				expect_equal("num_inst", num_inst, hold_inst);
				expect_equal("output_port", output_port, hold_out);
				expect_equal("address1", address1, hold_pc);
				expect_equal("address2", address2, hold_addr);
			end
			expect_equal("unconsumed WWD values", 16'(wwd_q.size()), 16'd0);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* build.f */
cpu_pkg.sv
control_unit.sv
register_file.sv
alu.sv
hazard_unit.sv
datapath.sv
tb_cpu_props.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
